//--- rtl/perf_pkg.sv
package perf_pkg;

	// One pipeline sample per cycle
	typedef struct packed {
		logic if_stall;
		logic flush;
		logic jb_sel;
	} pipe_status_t;

	// One memory-system sample per cycle
	typedef struct packed {
		// L1 instruction cache
		logic l1i_miss;
		logic read_a;
		// L1 data cache
		logic l1d_miss;
		logic read_b;
		logic write_b;
		// Shared L2
		logic l2_miss;
		logic read_l2;
		logic write_l2;
		logic resp_l2;
		// I/D arbiter requests
		logic read_i;
		logic read_d;
		logic write_d;
	} cache_status_t;

	// Qualified single-cycle event flags
	typedef struct packed {
		logic br_miss;
		logic br_total;
		logic l1i_miss;
		logic l1i_total;
		logic l1d_miss;
		logic l1d_total;
		logic l2_miss;
		logic l2_total;
		logic id_conflict;
	} perf_event_t;

	// Register index of each counter
	typedef enum logic [3:0] {
		BR_MISS     = 4'd0,
		BR_TOTAL    = 4'd1,
		L1I_MISS    = 4'd2,
		L1I_TOTAL   = 4'd3,
		L1D_MISS    = 4'd4,
		L1D_TOTAL   = 4'd5,
		L2_MISS     = 4'd6,
		L2_TOTAL    = 4'd7,
		ID_CONFLICT = 4'd8
	} counter_idx_e;

	localparam int unsigned NUM_COUNTERS = 9;

	// How far a miss count may lead its total before a restart
	localparam int unsigned L1_MISS_LEAD = 0;
	// L2 total only moves on the response, so the miss side runs one ahead
	localparam int unsigned L2_MISS_LEAD = 1;

endpackage

//--- rtl/mmio_pkg.sv
package mmio_pkg;

	// Register port widths
	localparam int unsigned DATA_WIDTH = 32;
	localparam int unsigned ADDR_WIDTH = 4;

	// Read request strobe with word address
	typedef struct packed {
		logic                  valid;
		logic [ADDR_WIDTH-1:0] addr;
	} rd_req_t;

	// Read response pulse with data
	typedef struct packed {
		logic                  valid;
		logic [DATA_WIDTH-1:0] data;
	} rd_rsp_t;

endpackage

//--- rtl/perf_event_capture.sv
`timescale 1ns/1ps

module perf_event_capture (
	input  logic                    clk,
	input  logic                    reset,
	input  perf_pkg::pipe_status_t  pipe,
	input  perf_pkg::cache_status_t cache,
	output perf_pkg::perf_event_t   events
);

	// Flush level from the previous cycle
	logic flush_q;
	// Qualified events before the register
	perf_pkg::perf_event_t events_d;
	logic fetch_ok;
	logic l2_req;
	logic d_req;

	// Accesses only count when the front end is not stalled
	assign fetch_ok = !pipe.if_stall;
	assign l2_req   = cache.read_l2 | cache.write_l2;
	assign d_req    = cache.read_d | cache.write_d;

	always_comb
	begin
		// A held flush is one misprediction, so only the rising edge counts
		events_d.br_miss     = pipe.flush & ~flush_q;
		events_d.br_total    = pipe.jb_sel & fetch_ok;

		// L1 instruction side
		events_d.l1i_miss    = cache.l1i_miss;
		events_d.l1i_total   = cache.read_a & fetch_ok;

		// L1 data side
		events_d.l1d_miss    = cache.l1d_miss;
		events_d.l1d_total   = (cache.read_b | cache.write_b) & fetch_ok;

		// L2 access counts once the response arrives
		events_d.l2_miss     = cache.l2_miss;
		events_d.l2_total    = l2_req & cache.resp_l2;

		// Both L1s asking the arbiter in the same cycle
		events_d.id_conflict = cache.read_i & d_req;
	end

	// Edge history
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flush_q <= 1'b0;
		end
		else
		begin
			flush_q <= pipe.flush;
		end
	end

	// One clean event vector per cycle for the bank
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			events <= '0;
		end
		else
		begin
			events <= events_d;
		end
	end

endmodule

//--- rtl/perf_counter_bank.sv
`timescale 1ns/1ps

module perf_counter_bank #(
	parameter int unsigned COUNTER_WIDTH = 32
) (
	input  logic                                                 clk,
	input  logic                                                 reset,
	input  perf_pkg::perf_event_t                                events,
	output logic [perf_pkg::NUM_COUNTERS-1:0][COUNTER_WIDTH-1:0] counts
);

	typedef logic [COUNTER_WIDTH-1:0] count_t;

	// Values to load on the next edge
	logic [perf_pkg::NUM_COUNTERS-1:0][COUNTER_WIDTH-1:0] counts_nxt;

	// Totals and conflicts simply wrap
	function automatic count_t bump(input count_t cnt, input logic ev);
		if (ev)
			return cnt + 1'b1;
		return cnt;
	endfunction

	// Miss counter step
	// Compare one bit wider so total plus lead cannot wrap
	function automatic count_t miss_next(
		input count_t      miss,
		input count_t      total,
		input int unsigned lead,
		input logic        ev
	);
		logic [COUNTER_WIDTH:0] limit;
		limit = {1'b0, total} + (COUNTER_WIDTH+1)'(lead);
		if (!ev)
			return miss;
		// Miss count got ahead of its total, start over
		if ({1'b0, miss} > limit)
			return count_t'(1);
		return miss + 1'b1;
	endfunction

	always_comb
	begin
		// Branch pair, no lead like the L1 pairs
		counts_nxt[perf_pkg::BR_MISS] = miss_next(
			counts[perf_pkg::BR_MISS],
			counts[perf_pkg::BR_TOTAL],
			perf_pkg::L1_MISS_LEAD,
			events.br_miss
		);
		counts_nxt[perf_pkg::BR_TOTAL] = bump(
			counts[perf_pkg::BR_TOTAL],
			events.br_total
		);

		// L1 instruction pair
		counts_nxt[perf_pkg::L1I_MISS] = miss_next(
			counts[perf_pkg::L1I_MISS],
			counts[perf_pkg::L1I_TOTAL],
			perf_pkg::L1_MISS_LEAD,
			events.l1i_miss
		);
		counts_nxt[perf_pkg::L1I_TOTAL] = bump(
			counts[perf_pkg::L1I_TOTAL],
			events.l1i_total
		);

		// L1 data pair
		counts_nxt[perf_pkg::L1D_MISS] = miss_next(
			counts[perf_pkg::L1D_MISS],
			counts[perf_pkg::L1D_TOTAL],
			perf_pkg::L1_MISS_LEAD,
			events.l1d_miss
		);
		counts_nxt[perf_pkg::L1D_TOTAL] = bump(
			counts[perf_pkg::L1D_TOTAL],
			events.l1d_total
		);

		// L2 pair, miss may lead by one
		counts_nxt[perf_pkg::L2_MISS] = miss_next(
			counts[perf_pkg::L2_MISS],
			counts[perf_pkg::L2_TOTAL],
			perf_pkg::L2_MISS_LEAD,
			events.l2_miss
		);
		counts_nxt[perf_pkg::L2_TOTAL] = bump(
			counts[perf_pkg::L2_TOTAL],
			events.l2_total
		);

		// Arbiter conflicts have no pair
		counts_nxt[perf_pkg::ID_CONFLICT] = bump(
			counts[perf_pkg::ID_CONFLICT],
			events.id_conflict
		);
	end

	// All nine counters move on the same edge
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			counts <= '0;
		end
		else
		begin
			counts <= counts_nxt;
		end
	end

endmodule

//--- rtl/perf_readout.sv
`timescale 1ns/1ps

module perf_readout #(
	parameter int unsigned COUNTER_WIDTH = 32
) (
	input  logic                                                 clk,
	input  logic                                                 reset,
	input  logic [perf_pkg::NUM_COUNTERS-1:0][COUNTER_WIDTH-1:0] counts,
	input  mmio_pkg::rd_req_t                                    rd_req,
	output mmio_pkg::rd_rsp_t                                    rd_rsp
);

	localparam int unsigned NUM_REGS = perf_pkg::NUM_COUNTERS;

	// Selected word before the response register
	logic [mmio_pkg::DATA_WIDTH-1:0] sel_data;
	logic                            addr_hit;
	// Response register
	logic                            rsp_valid;
	logic [mmio_pkg::DATA_WIDTH-1:0] rsp_data;

	// Only the first nine word addresses are mapped
	assign addr_hit = 32'(rd_req.addr) < NUM_REGS;

	always_comb
	begin
		sel_data = '0;
		if (addr_hit)
		begin
			// Upper bits stay zero for narrow counters
			sel_data[COUNTER_WIDTH-1:0] = counts[rd_req.addr];
		end
	end

	// One response pulse per request
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rsp_valid <= 1'b0;
		end
		else
		begin
			rsp_valid <= rd_req.valid;
		end
	end

	// Data only follows an accepted request
	always_ff @(posedge clk)
	begin
		if (rd_req.valid)
		begin
			rsp_data <= sel_data;
		end
	end

	assign rd_rsp.valid = rsp_valid;
	assign rd_rsp.data  = rsp_data;

endmodule

//--- rtl/perf_monitor_top.sv
`timescale 1ns/1ps

module perf_monitor_top #(
	parameter int unsigned COUNTER_WIDTH = 32
) (
	input  logic                    clk,
	input  logic                    reset,
	input  perf_pkg::pipe_status_t  pipe,
	input  perf_pkg::cache_status_t cache,
	input  mmio_pkg::rd_req_t       rd_req,
	output mmio_pkg::rd_rsp_t       rd_rsp
);

	// Registered event flags, one cycle after the samples
	perf_pkg::perf_event_t events;

	// Live counter values for the read port
	logic [perf_pkg::NUM_COUNTERS-1:0][COUNTER_WIDTH-1:0] counts;

	// Input side, strobes to events
	perf_event_capture u_capture (
		.clk    (clk),
		.reset  (reset),
		.pipe   (pipe),
		.cache  (cache),
		.events (events)
	);

	// Event counters
	perf_counter_bank #(
		.COUNTER_WIDTH (COUNTER_WIDTH)
	) u_bank (
		.clk    (clk),
		.reset  (reset),
		.events (events),
		.counts (counts)
	);

	// Register read port
	perf_readout #(
		.COUNTER_WIDTH (COUNTER_WIDTH)
	) u_readout (
		.clk    (clk),
		.reset  (reset),
		.counts (counts),
		.rd_req (rd_req),
		.rd_rsp (rd_rsp)
	);

endmodule

//--- test/perf_monitor_tb.sv
`timescale 1ns/1ps

module perf_monitor_tb;

	localparam int COUNTER_WIDTH = 32;
	localparam int ADDR_W = mmio_pkg::ADDR_WIDTH;
	localparam int NUM_REGS = 1 << ADDR_W;
	localparam int RANDOM_CYCLES = 500;
	// Full run is well under a thousand cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk = 1'b0;
	logic reset;
	perf_pkg::pipe_status_t pipe;
	perf_pkg::cache_status_t cache;
	mmio_pkg::rd_req_t rd_req;
	mmio_pkg::rd_rsp_t rd_rsp;

	// Reference model state
	logic [COUNTER_WIDTH-1:0] exp_count [perf_pkg::NUM_COUNTERS];
	logic model_flush_prev;
	logic [31:0] rng_state;

	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int unsigned cycle_count = 0;

	perf_monitor_top #(
		.COUNTER_WIDTH (COUNTER_WIDTH)
	) dut (
		.clk    (clk),
		.reset  (reset),
		.pipe   (pipe),
		.cache  (cache),
		.rd_req (rd_req),
		.rd_rsp (rd_rsp)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
	end

	initial
	begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] v;
		v = x;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic string reg_name(input int addr);
		perf_pkg::counter_idx_e idx;
		if (addr >= perf_pkg::NUM_COUNTERS)
			return $sformatf("unmapped register %0d", addr);
		idx = perf_pkg::counter_idx_e'(addr);
		return idx.name();
	endfunction

	// Miss rule, compared against the totals before this cycle
	function automatic logic [COUNTER_WIDTH-1:0] next_miss(
		input logic [COUNTER_WIDTH-1:0] miss,
		input logic [COUNTER_WIDTH-1:0] total,
		input int unsigned              lead
	);
		longint unsigned limit;
		limit = longint'(total) + longint'(lead);
		if (longint'(miss) > limit)
			return 1;
		return miss + 1;
	endfunction

	function automatic logic [mmio_pkg::DATA_WIDTH-1:0] expected_read(input int addr);
		logic [mmio_pkg::DATA_WIDTH-1:0] v;
		v = '0;
		if (addr < perf_pkg::NUM_COUNTERS)
			v[COUNTER_WIDTH-1:0] = exp_count[addr];
		return v;
	endfunction

	task automatic model_step(input perf_pkg::pipe_status_t p, input perf_pkg::cache_status_t c);
		logic [COUNTER_WIDTH-1:0] old [perf_pkg::NUM_COUNTERS];
		logic run;
		old = exp_count;
		run = !p.if_stall;
		if (p.flush && !model_flush_prev)
			exp_count[perf_pkg::BR_MISS] = next_miss(old[perf_pkg::BR_MISS],
				old[perf_pkg::BR_TOTAL], perf_pkg::L1_MISS_LEAD);
		if (p.jb_sel && run)
			exp_count[perf_pkg::BR_TOTAL] = old[perf_pkg::BR_TOTAL] + 1;
		if (c.l1i_miss)
			exp_count[perf_pkg::L1I_MISS] = next_miss(old[perf_pkg::L1I_MISS],
				old[perf_pkg::L1I_TOTAL], perf_pkg::L1_MISS_LEAD);
		if (c.read_a && run)
			exp_count[perf_pkg::L1I_TOTAL] = old[perf_pkg::L1I_TOTAL] + 1;
		if (c.l1d_miss)
			exp_count[perf_pkg::L1D_MISS] = next_miss(old[perf_pkg::L1D_MISS],
				old[perf_pkg::L1D_TOTAL], perf_pkg::L1_MISS_LEAD);
		if ((c.read_b || c.write_b) && run)
			exp_count[perf_pkg::L1D_TOTAL] = old[perf_pkg::L1D_TOTAL] + 1;
		if (c.l2_miss)
			exp_count[perf_pkg::L2_MISS] = next_miss(old[perf_pkg::L2_MISS],
				old[perf_pkg::L2_TOTAL], perf_pkg::L2_MISS_LEAD);
		if ((c.read_l2 || c.write_l2) && c.resp_l2)
			exp_count[perf_pkg::L2_TOTAL] = old[perf_pkg::L2_TOTAL] + 1;
		if (c.read_i && (c.read_d || c.write_d))
			exp_count[perf_pkg::ID_CONFLICT] = old[perf_pkg::ID_CONFLICT] + 1;
		model_flush_prev = p.flush;
	endtask

	task automatic drive_cycle(input perf_pkg::pipe_status_t p, input perf_pkg::cache_status_t c);
		@(posedge clk);
		pipe <= p;
		cache <= c;
		model_step(p, c);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_cycle('0, '0);
	endtask

	task automatic check_data(
		input mmio_pkg::rd_rsp_t               rsp,
		input logic [mmio_pkg::DATA_WIDTH-1:0] expected,
		input string                           name
	);
		if (rsp.data !== expected)
		begin
			errors++;
			$display("Error at %0t: %s read %0d, expected %0d", $time, name, rsp.data, expected);
		end
	endtask

	task automatic check_valid(input mmio_pkg::rd_rsp_t rsp, input logic expected, input string what);
		if (rsp.valid !== expected)
		begin
			errors++;
			if (expected)
				$display("No response pulse for the read of %s at time %0t", what, $time);
			else
				$display("Extra response pulse %s at time %0t", what, $time);
		end
	endtask

	// Back-to-back requests; each answer shows up one cycle after its request
	task automatic read_regs(input int first, input int count);
		mmio_pkg::rd_req_t req;
		for (int i = 0; i <= count; i++)
		begin
			@(posedge clk);
			if (i < count)
			begin
				req.valid = 1'b1;
				req.addr = ADDR_W'(first + i);
				rd_req <= req;
			end
			else
			begin
				rd_req <= '0;
			end
			@(negedge clk);
			if (i == 0)
			begin
				check_valid(rd_rsp, 1'b0, "before the first request");
			end
			else
			begin
				check_valid(rd_rsp, 1'b1, reg_name(first + i - 1));
				check_data(rd_rsp, expected_read(first + i - 1), reg_name(first + i - 1));
			end
		end
		@(negedge clk);
		check_valid(rd_rsp, 1'b0, "after the last response");
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
		begin
			tests_passed++;
			$display("Test %-22s ok", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %-22s %0d mismatches", name, errors - errors_before);
		end
	endtask

	task automatic test_reset_state();
		int start;
		start = errors;
		read_regs(0, perf_pkg::NUM_COUNTERS);
		report_test("reset state", start);
	endtask

	task automatic test_branch_counting();
		int start;
		start = errors;
		// Held flush, one misprediction
		drive_cycle('{if_stall: 1'b0, flush: 1'b1, jb_sel: 1'b1}, '0);
		repeat (3) drive_cycle('{if_stall: 1'b0, flush: 1'b1, jb_sel: 1'b0}, '0);
		idle_cycles(1);
		drive_cycle('{if_stall: 1'b0, flush: 1'b1, jb_sel: 1'b1}, '0);
		idle_cycles(1);
		// Stalled branch is not counted
		drive_cycle('{if_stall: 1'b1, flush: 1'b0, jb_sel: 1'b1}, '0);
		drive_cycle('{if_stall: 1'b0, flush: 1'b0, jb_sel: 1'b1}, '0);
		idle_cycles(3);
		read_regs(0, 2);
		report_test("branch counting", start);
	endtask

	task automatic test_l1_counting();
		perf_pkg::cache_status_t c;
		int start;
		start = errors;
		c = '0;
		c.read_a = 1'b1;
		repeat (3) drive_cycle('0, c);
		drive_cycle('{if_stall: 1'b1, flush: 1'b0, jb_sel: 1'b0}, c);
		c = '0;
		c.read_b = 1'b1;
		repeat (2) drive_cycle('0, c);
		c = '0;
		c.write_b = 1'b1;
		drive_cycle('{if_stall: 1'b1, flush: 1'b0, jb_sel: 1'b0}, c);
		drive_cycle('0, c);
		c = '0;
		c.l1i_miss = 1'b1;
		c.l1d_miss = 1'b1;
		drive_cycle('0, c);
		c.l1d_miss = 1'b0;
		// Misses outrun the accesses here, so the last one restarts
		repeat (4) drive_cycle('0, c);
		idle_cycles(3);
		read_regs(2, 4);
		report_test("L1 counting", start);
	endtask

	task automatic test_l2_counting();
		perf_pkg::cache_status_t c;
		int start;
		start = errors;
		c = '0;
		c.read_l2 = 1'b1;
		drive_cycle('0, c);
		c.resp_l2 = 1'b1;
		drive_cycle('0, c);
		c = '0;
		c.write_l2 = 1'b1;
		c.resp_l2 = 1'b1;
		drive_cycle('0, c);
		c.write_l2 = 1'b0;
		drive_cycle('0, c);
		c = '0;
		c.l2_miss = 1'b1;
		repeat (5) drive_cycle('0, c);
		idle_cycles(3);
		read_regs(6, 2);
		report_test("L2 counting", start);
	endtask

	task automatic test_conflicts_and_map();
		perf_pkg::cache_status_t c;
		int start;
		start = errors;
		c = '0;
		c.read_i = 1'b1;
		repeat (2) drive_cycle('0, c);
		c.read_d = 1'b1;
		repeat (2) drive_cycle('0, c);
		c.read_d = 1'b0;
		c.write_d = 1'b1;
		drive_cycle('0, c);
		c = '0;
		c.read_d = 1'b1;
		drive_cycle('0, c);
		idle_cycles(3);
		read_regs(perf_pkg::NUM_COUNTERS - 1, NUM_REGS - perf_pkg::NUM_COUNTERS + 1);
		read_regs(0, perf_pkg::NUM_COUNTERS);
		report_test("conflicts and map", start);
	endtask

	task automatic test_random_stream();
		int start;
		start = errors;
		for (int i = 0; i < RANDOM_CYCLES; i++)
		begin
			rng_state = xorshift32(rng_state);
			drive_cycle(perf_pkg::pipe_status_t'(rng_state[2:0]),
				perf_pkg::cache_status_t'(rng_state[14:3]));
		end
		idle_cycles(3);
		read_regs(0, perf_pkg::NUM_COUNTERS);
		report_test("random stream", start);
	endtask

	initial
	begin
		reset = 1'b1;
		pipe = '0;
		cache = '0;
		rd_req = '0;
		for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
			exp_count[i] = '0;
		model_flush_prev = 1'b0;
		rng_state = 32'h1356abf9;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		test_reset_state();
		test_branch_counting();
		test_l1_counting();
		test_l2_counting();
		test_conflicts_and_map();
		test_random_stream();

		$display("Tests passed %0d, tests failed %0d, check errors %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- sim.f
rtl/perf_pkg.sv
rtl/mmio_pkg.sv
rtl/perf_event_capture.sv
rtl/perf_counter_bank.sv
rtl/perf_readout.sv
rtl/perf_monitor_top.sv
test/perf_monitor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the performance monitor testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module perf_monitor_tb \
	-o perf_monitor_sim || { echo "Verilator build failed"; exit 1; }

./obj_dir/perf_monitor_sim > sim.log 2>&1
cat sim.log

# Any failed check or a timeout leaves the fail message in the log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
